// File: hw/bus_arbiter.sv
module bus_arbiter #(
  parameter int BLOCK_BEATS = 8
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      fetch_req,
  input  rv_core_pkg::blk_req_t     fetch_blk,
  output logic                      fetch_done,
  output logic [BLOCK_BEATS*64-1:0] fetch_data,
  input  logic                      data_req,
  input  rv_core_pkg::blk_req_t     data_blk,
  input  logic [BLOCK_BEATS*64-1:0] data_wblock,
  output logic                      data_done,
  output logic [BLOCK_BEATS*64-1:0] data_rblock,
  output logic                      start,
  output rv_core_pkg::blk_req_t     start_req,
  output logic [BLOCK_BEATS*64-1:0] start_wblock,
  input  logic                      busy,
  input  logic                      ctrl_done,
  input  logic [BLOCK_BEATS*64-1:0] ctrl_rblock
);

  logic owner_active;
  logic owner_id;

  // data side wins a tie
  assign start = !owner_active && !busy && (fetch_req || data_req);
  assign start_req = data_req ? data_blk : fetch_blk;
  assign start_wblock = data_wblock;

  assign fetch_done = ctrl_done && owner_active && !owner_id;
  assign data_done = ctrl_done && owner_active && owner_id;
  assign fetch_data = ctrl_rblock;
  assign data_rblock = ctrl_rblock;

  always_ff @(posedge clk) begin
    if (reset) begin
      owner_active <= 1'b0;
      owner_id <= 1'b0;
    end else if (start) begin
      owner_active <= 1'b1;
      owner_id <= data_req;
    end else if (ctrl_done) begin
      owner_active <= 1'b0;
    end
  end

  // every controller completion goes back to exactly one requestor
  a_one_done: assert property (@(posedge clk) disable iff (reset)
    ctrl_done |-> $onehot({fetch_done, data_done}));

endmodule

// File: hw/bus_controller.sv
module bus_controller #(
  parameter int BLOCK_BEATS = 8
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  rv_core_pkg::blk_req_t     start_req,
  input  logic [BLOCK_BEATS*64-1:0] start_wblock,
  output logic                      busy,
  output logic                      ctrl_done,
  output logic [BLOCK_BEATS*64-1:0] ctrl_rblock,
  output logic                      bus_reqcyc,
  output logic                      bus_respack,
  output rv_core_pkg::word_t        bus_req,
  output rv_core_pkg::bus_tag_t     bus_reqtag,
  input  logic                      bus_respcyc,
  input  logic                      bus_reqack,
  input  rv_core_pkg::word_t        bus_resp,
  input  rv_core_pkg::bus_tag_t     bus_resptag
);

  localparam int IDX_W = $clog2(BLOCK_BEATS);

  typedef enum logic [2:0] {C_IDLE, C_ADDR, C_WRITE, C_READ, C_DONE} ctrl_state_e;

  ctrl_state_e               state;
  rv_core_pkg::blk_req_t     req_q;
  logic [BLOCK_BEATS*64-1:0] wblock_q;
  logic [IDX_W-1:0]          beat_cnt;
  logic                      last_beat;

  assign last_beat = (beat_cnt == IDX_W'(BLOCK_BEATS - 1));
  assign busy = (state != C_IDLE);
  assign ctrl_done = (state == C_DONE);

  // address beat first, then the write data beats under the same tag
  assign bus_reqcyc = (state == C_ADDR) || (state == C_WRITE);
  assign bus_req = (state == C_WRITE) ? wblock_q[beat_cnt*64 +: 64] : req_q.addr;
  assign bus_reqtag = rv_core_pkg::make_tag(req_q);
  assign bus_respack = (state == C_READ) && bus_respcyc;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= C_IDLE;
      beat_cnt <= '0;
    end else begin
      case (state)
        C_IDLE: begin
          if (start) begin
            state <= C_ADDR;
          end
        end
        C_ADDR: begin
          if (bus_reqack) begin
            beat_cnt <= '0;
            state <= req_q.write ? C_WRITE : C_READ;
          end
        end
        C_WRITE: begin
          if (bus_reqack) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) begin
              state <= C_DONE;
            end
          end
        end
        C_READ: begin
          if (bus_respcyc) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) begin
              state <= C_DONE;
            end
          end
        end
        default: state <= C_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == C_IDLE && start) begin
      req_q <= start_req;
      wblock_q <= start_wblock;
    end
    if (state == C_READ && bus_respcyc) begin
      ctrl_rblock[beat_cnt*64 +: 64] <= bus_resp;
    end
  end

  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    bus_reqcyc && !bus_reqack |=> $stable(bus_req) && $stable(bus_reqtag));

  a_resp_tag: assert property (@(posedge clk) disable iff (reset)
    bus_respack |-> bus_resptag == bus_reqtag);

endmodule

// File: hw/execute_unit.sv
module execute_unit #(
  parameter int BLOCK_BEATS = 8
) (
  input  logic                      clk,
  input  logic                      reset,
  input  rv_core_pkg::decoded_op_t  dec_op,
  input  logic                      dec_valid,
  output logic                      rf_we,
  output logic [4:0]                rf_rd,
  output rv_core_pkg::word_t        rf_wdata,
  output logic                      retire,
  output logic                      halted,
  output logic                      data_req,
  output rv_core_pkg::blk_req_t     data_blk,
  output logic [BLOCK_BEATS*64-1:0] data_wblock,
  input  logic                      data_done,
  input  logic [BLOCK_BEATS*64-1:0] data_rblock
);

  localparam int OFS_W = $clog2(BLOCK_BEATS * 8);

  typedef enum logic [1:0] {X_IDLE, X_READ, X_WRITE} exec_state_e;

  exec_state_e               state;
  rv_core_pkg::word_t        opb;
  rv_core_pkg::word_t        alu_res;
  rv_core_pkg::word_t        mem_addr;
  rv_core_pkg::word_t        st_data;
  logic                      is_store;
  logic [4:0]                mem_rd;
  logic [OFS_W-4:0]          dw_idx;
  logic [BLOCK_BEATS*64-1:0] dbuf;
  logic [BLOCK_BEATS*64-1:0] merged;

  always_comb begin
    opb = dec_op.use_imm ? dec_op.imm : dec_op.b;
    case (dec_op.kind)
      rv_core_pkg::ALU_SUB: alu_res = dec_op.a - opb;
      rv_core_pkg::ALU_AND: alu_res = dec_op.a & opb;
      rv_core_pkg::ALU_OR:  alu_res = dec_op.a | opb;
      rv_core_pkg::ALU_XOR: alu_res = dec_op.a ^ opb;
      rv_core_pkg::OP_LUI:  alu_res = dec_op.imm;
      // also the effective address of LD and SD
      default:              alu_res = dec_op.a + opb;
    endcase
  end

  assign dw_idx = mem_addr[OFS_W-1:3];

  // fresh block with the store doubleword dropped in
  always_comb begin
    merged = data_rblock;
    merged[dw_idx*64 +: 64] = st_data;
  end

  assign data_wblock = dbuf;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= X_IDLE;
      rf_we <= 1'b0;
      retire <= 1'b0;
      halted <= 1'b0;
      data_req <= 1'b0;
    end else begin
      rf_we <= 1'b0;
      retire <= 1'b0;
      case (state)
        X_IDLE: begin
          if (dec_valid && !halted) begin
            case (dec_op.kind)
              rv_core_pkg::OP_LD, rv_core_pkg::OP_SD: begin
                data_req <= 1'b1;
                state <= X_READ;
              end
              rv_core_pkg::OP_ECALL, rv_core_pkg::OP_ILLEGAL: halted <= 1'b1;
              default: begin
                rf_we <= 1'b1;
                retire <= 1'b1;
              end
            endcase
          end
        end
        X_READ: begin
          if (data_done && is_store) begin
            state <= X_WRITE;
          end else if (data_done) begin
            rf_we <= 1'b1;
            retire <= 1'b1;
            data_req <= 1'b0;
            state <= X_IDLE;
          end
        end
        default: begin
          if (data_done) begin
            retire <= 1'b1;
            data_req <= 1'b0;
            state <= X_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == X_IDLE && dec_valid) begin
      rf_rd <= dec_op.rd;
      rf_wdata <= alu_res;
      mem_addr <= alu_res;
      mem_rd <= dec_op.rd;
      st_data <= dec_op.b;
      is_store <= (dec_op.kind == rv_core_pkg::OP_SD);
      data_blk <= '{addr: {alu_res[63:OFS_W], {OFS_W{1'b0}}}, write: 1'b0, id: 1'b1};
    end
    if (state == X_READ && data_done) begin
      rf_rd <= mem_rd;
      rf_wdata <= data_rblock[dw_idx*64 +: 64];
      dbuf <= merged;
      data_blk.write <= is_store;
    end
  end

endmodule

// File: hw/fetch_unit.sv
module fetch_unit #(
  parameter int BLOCK_BEATS = 8
) (
  input  logic                          clk,
  input  logic                          reset,
  input  rv_core_pkg::word_t            entry,
  input  logic                          retire,
  output rv_core_pkg::instr_u           instr,
  output rv_core_pkg::word_t            pc,
  output logic                          instr_valid,
  output logic                          fetch_req,
  output rv_core_pkg::blk_req_t         fetch_blk,
  input  logic                          fetch_done,
  input  logic [BLOCK_BEATS*64-1:0]     fetch_data
);

  localparam int OFS_W = $clog2(BLOCK_BEATS * 8);

  typedef enum logic [1:0] {F_LOOK, F_MISS, F_WAIT} fetch_state_e;

  fetch_state_e              state;
  logic                      buf_valid;
  logic [63:OFS_W]           buf_tag;
  logic [BLOCK_BEATS*64-1:0] buf_data;
  logic [OFS_W-3:0]          word_idx;
  logic                      hit;

  assign word_idx = pc[OFS_W-1:2];
  assign hit = buf_valid && (buf_tag == pc[63:OFS_W]);

  // always the block that holds pc
  assign fetch_blk = '{addr: {pc[63:OFS_W], {OFS_W{1'b0}}}, write: 1'b0, id: 1'b0};

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= F_LOOK;
      pc <= entry;
      buf_valid <= 1'b0;
      fetch_req <= 1'b0;
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= 1'b0;
      case (state)
        F_LOOK: begin
          if (hit) begin
            instr_valid <= 1'b1;
            state <= F_WAIT;
          end else begin
            fetch_req <= 1'b1;
            state <= F_MISS;
          end
        end
        F_MISS: begin
          if (fetch_done) begin
            fetch_req <= 1'b0;
            buf_valid <= 1'b1;
            state <= F_LOOK;
          end
        end
        default: begin
          // hold the instruction until execute is finished with it
          if (retire) begin
            pc <= pc + 64'd4;
            state <= F_LOOK;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == F_MISS && fetch_done) begin
      buf_data <= fetch_data;
      buf_tag <= pc[63:OFS_W];
    end
    if (state == F_LOOK && hit) begin
      instr <= buf_data[word_idx*32 +: 32];
    end
  end

  a_no_issue_on_miss: assert property (@(posedge clk) disable iff (reset)
    instr_valid |-> !fetch_req);

endmodule

// File: hw/register_decode.sv
module register_decode (
  input  logic                      clk,
  input  logic                      reset,
  input  rv_core_pkg::word_t        stackptr,
  input  rv_core_pkg::instr_u       instr,
  input  logic                      instr_valid,
  input  logic                      rf_we,
  input  logic [4:0]                rf_rd,
  input  rv_core_pkg::word_t        rf_wdata,
  output rv_core_pkg::decoded_op_t  dec_op,
  output logic                      dec_valid
);

  rv_core_pkg::word_t       regs [32];
  rv_core_pkg::decoded_op_t dec_next;
  rv_core_pkg::word_t       i_imm;
  rv_core_pkg::word_t       s_imm;
  rv_core_pkg::word_t       u_imm;

  // x0 is never written, so it stays zero after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= (i == 2) ? stackptr : '0;
      end
    end else if (rf_we && rf_rd != 5'd0) begin
      regs[rf_rd] <= rf_wdata;
    end
  end

  assign i_imm = {{52{instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
  // store offset sits in the funct7 and rd fields
  assign s_imm = {{52{instr.r_fmt.funct7[6]}}, instr.r_fmt.funct7, instr.r_fmt.rd};
  assign u_imm = {{32{instr.r_fmt.funct7[6]}}, instr.r_fmt.funct7, instr.r_fmt.rs2,
                  instr.r_fmt.rs1, instr.r_fmt.funct3, 12'b0};

  always_comb begin
    dec_next.kind = rv_core_pkg::OP_ILLEGAL;
    dec_next.rd = instr.i_fmt.rd;
    dec_next.a = regs[instr.r_fmt.rs1];
    dec_next.b = regs[instr.r_fmt.rs2];
    dec_next.imm = i_imm;
    dec_next.use_imm = 1'b1;
    case (instr.r_fmt.opcode)
      rv_core_pkg::OPC_OP: begin
        dec_next.use_imm = 1'b0;
        case ({instr.r_fmt.funct7, instr.r_fmt.funct3})
          10'b0000000_000: dec_next.kind = rv_core_pkg::ALU_ADD;
          10'b0100000_000: dec_next.kind = rv_core_pkg::ALU_SUB;
          10'b0000000_111: dec_next.kind = rv_core_pkg::ALU_AND;
          10'b0000000_110: dec_next.kind = rv_core_pkg::ALU_OR;
          10'b0000000_100: dec_next.kind = rv_core_pkg::ALU_XOR;
          default:         dec_next.kind = rv_core_pkg::OP_ILLEGAL;
        endcase
      end
      rv_core_pkg::OPC_OP_IMM: begin
        if (instr.i_fmt.funct3 == 3'b000) begin
          dec_next.kind = rv_core_pkg::ALU_ADD;
        end
      end
      rv_core_pkg::OPC_LUI: begin
        dec_next.kind = rv_core_pkg::OP_LUI;
        dec_next.imm = u_imm;
      end
      rv_core_pkg::OPC_LOAD: begin
        if (instr.i_fmt.funct3 == 3'b011) begin
          dec_next.kind = rv_core_pkg::OP_LD;
        end
      end
      rv_core_pkg::OPC_STORE: begin
        if (instr.r_fmt.funct3 == 3'b011) begin
          dec_next.kind = rv_core_pkg::OP_SD;
          dec_next.imm = s_imm;
        end
      end
      rv_core_pkg::OPC_SYSTEM: begin
        if (instr.i_fmt.imm12 == 12'd0 && instr.i_fmt.funct3 == 3'd0) begin
          dec_next.kind = rv_core_pkg::OP_ECALL;
        end
      end
      default: dec_next.kind = rv_core_pkg::OP_ILLEGAL;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= instr_valid;
    end
    if (instr_valid) begin
      dec_op <= dec_next;
    end
  end

endmodule

// File: hw/rv_core_pkg.sv
package rv_core_pkg;

  typedef logic [63:0] word_t;

  // the two field layouts of a 32-bit instruction word
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    OP_LUI,
    OP_LD,
    OP_SD,
    OP_ECALL,
    OP_ILLEGAL
  } op_kind_e;

  typedef struct packed {
    op_kind_e    kind;
    logic [4:0]  rd;
    word_t       a;
    word_t       b;
    word_t       imm;
    logic        use_imm;
  } decoded_op_t;

  // id 0 is fetch, id 1 is data
  typedef struct packed {
    word_t addr;
    logic  write;
    logic  id;
  } blk_req_t;

  typedef logic [12:0] bus_tag_t;

  localparam int TAG_WRITE_BIT = 12;
  localparam int TAG_ID_BIT    = 0;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  function automatic bus_tag_t make_tag(blk_req_t req);
    bus_tag_t tag;
    tag = '0;
    tag[TAG_WRITE_BIT] = req.write;
    tag[TAG_ID_BIT] = req.id;
    return tag;
  endfunction

endpackage

// File: hw/rv_core_top.sv
module rv_core_top #(
  parameter int BLOCK_BEATS = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  // program entry point and initial stack pointer
  input  rv_core_pkg::word_t    entry,
  input  rv_core_pkg::word_t    stackptr,
  output logic                  halted,
  output logic                  bus_reqcyc,
  output logic                  bus_respack,
  output rv_core_pkg::word_t    bus_req,
  output rv_core_pkg::bus_tag_t bus_reqtag,
  input  logic                  bus_respcyc,
  input  logic                  bus_reqack,
  input  rv_core_pkg::word_t    bus_resp,
  input  rv_core_pkg::bus_tag_t bus_resptag
);

  rv_core_pkg::instr_u       instr;
  logic                      instr_valid;
  logic                      retire;
  rv_core_pkg::decoded_op_t  dec_op;
  logic                      dec_valid;
  logic                      rf_we;
  logic [4:0]                rf_rd;
  rv_core_pkg::word_t        rf_wdata;

  logic                      fetch_req;
  rv_core_pkg::blk_req_t     fetch_blk;
  logic                      fetch_done;
  logic [BLOCK_BEATS*64-1:0] fetch_data;
  logic                      data_req;
  rv_core_pkg::blk_req_t     data_blk;
  logic [BLOCK_BEATS*64-1:0] data_wblock;
  logic                      data_done;
  logic [BLOCK_BEATS*64-1:0] data_rblock;

  logic                      start;
  rv_core_pkg::blk_req_t     start_req;
  logic [BLOCK_BEATS*64-1:0] start_wblock;
  logic                      busy;
  logic                      ctrl_done;
  logic [BLOCK_BEATS*64-1:0] ctrl_rblock;

  // pc only matters inside fetch
  fetch_unit #(.BLOCK_BEATS(BLOCK_BEATS)) u_fetch_unit (.pc(), .*);

  register_decode u_register_decode (.*);

  execute_unit #(.BLOCK_BEATS(BLOCK_BEATS)) u_execute_unit (.*);

  bus_arbiter #(.BLOCK_BEATS(BLOCK_BEATS)) u_bus_arbiter (.*);

  bus_controller #(.BLOCK_BEATS(BLOCK_BEATS)) u_bus_controller (.*);

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rv_core -f rv_core.f -o sim_rv_core
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_rv_core 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^TESTBENCH PASSED$"; then
  exit 0
fi
exit 1

// File: rv_core.f
hw/rv_core_pkg.sv
hw/fetch_unit.sv
hw/register_decode.sv
hw/execute_unit.sv
hw/bus_arbiter.sv
hw/bus_controller.sv
hw/rv_core_top.sv
test/tb_mem_model.sv
test/tb_rv_core.sv

// File: test/tb_mem_model.sv
module tb_mem_model #(
  parameter int BLOCK_BEATS = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [31:0]           rand_word,
  input  logic                  bus_reqcyc,
  input  logic                  bus_respack,
  input  rv_core_pkg::word_t    bus_req,
  input  rv_core_pkg::bus_tag_t bus_reqtag,
  output logic                  bus_respcyc,
  output logic                  bus_reqack,
  output rv_core_pkg::word_t    bus_resp,
  output rv_core_pkg::bus_tag_t bus_resptag,
  output int                    req_count,
  output int                    err_count
);

  typedef enum {M_IDLE, M_ADDR, M_WRITE, M_READ} mem_state_e;

  // 64 KB backing store, one entry per doubleword
  logic [63:0]           mem [8192];
  mem_state_e            mstate;
  logic [63:0]           cur_addr;
  rv_core_pkg::bus_tag_t cur_tag;
  logic [63:0]           beat_val;
  logic                  beat_seen;
  int                    beat;
  int                    delay;

  initial begin
    bus_respcyc = 1'b0;
    bus_reqack = 1'b0;
    bus_resp = '0;
    bus_resptag = '0;
    req_count = 0;
    err_count = 0;
    mstate = M_IDLE;
    beat = 0;
    delay = 0;
    beat_seen = 1'b0;
  end

  // all bus signals are sampled at the rising edge, before the DUT updates
  always @(posedge clk) begin
    bus_reqack <= 1'b0;
    bus_respcyc <= 1'b0;
    if (reset) begin
      mstate = M_IDLE;
    end else if (!bus_reqack) begin
      case (mstate)
        M_IDLE: begin
          if (bus_reqcyc) begin
            cur_addr = bus_req;
            cur_tag = bus_reqtag;
            req_count = req_count + 1;
            if (cur_addr % (BLOCK_BEATS * 8) != 0) begin
              err_count = err_count + 1;
              $display("bus request address %h at %0t is not block aligned", cur_addr, $time);
            end
            if ((cur_tag & 13'h0ffe) != 0) begin
              err_count = err_count + 1;
              $display("bus request tag %h at %0t has stray bits set", cur_tag, $time);
            end
            delay = int'(rand_word % 4);
            mstate = M_ADDR;
          end
        end
        M_ADDR: begin
          if (!bus_reqcyc || bus_req !== cur_addr || bus_reqtag !== cur_tag) begin
            err_count = err_count + 1;
            $display("address beat changed or dropped before acknowledge at %0t", $time);
          end
          if (delay == 0) begin
            bus_reqack <= 1'b1;
            beat = 0;
            beat_seen = 1'b0;
            delay = int'(rand_word % 4);
            mstate = cur_tag[12] ? M_WRITE : M_READ;
          end else begin
            delay = delay - 1;
          end
        end
        M_WRITE: begin
          if (!bus_reqcyc || bus_reqtag !== cur_tag || (beat_seen && bus_req !== beat_val)) begin
            err_count = err_count + 1;
            $display("write beat %0d changed or dropped before acknowledge at %0t", beat, $time);
          end
          beat_val = bus_req;
          beat_seen = 1'b1;
          if (delay == 0) begin
            bus_reqack <= 1'b1;
            mem[int'(cur_addr[15:3]) + beat] = bus_req;
            beat = beat + 1;
            beat_seen = 1'b0;
            delay = int'(rand_word % 4);
            if (beat == BLOCK_BEATS) begin
              mstate = M_IDLE;
            end
          end else begin
            delay = delay - 1;
          end
        end
        default: begin
          if (bus_reqcyc) begin
            err_count = err_count + 1;
            $display("request beat raised while a read was in progress at %0t", $time);
          end
          if (bus_respcyc) begin
            if (!bus_respack) begin
              err_count = err_count + 1;
              $display("read beat %0d was not acknowledged at %0t", beat, $time);
            end
            beat = beat + 1;
          end
          if (beat == BLOCK_BEATS) begin
            mstate = M_IDLE;
          end else if (delay == 0) begin
            bus_respcyc <= 1'b1;
            bus_resp <= mem[int'(cur_addr[15:3]) + beat];
            bus_resptag <= cur_tag;
            delay = int'(rand_word % 3);
          end else begin
            delay = delay - 1;
          end
        end
      endcase
    end
  end

endmodule

// File: test/tb_rv_core.sv
module tb_rv_core;

  localparam int          BLOCK_BEATS = 8;
  localparam int          N_RAND = 60;
  localparam logic [63:0] ENTRY = 64'h1000;
  localparam logic [63:0] STACK = 64'h8000;
  // doubleword indices of the blocks that the ±256 offsets can reach
  localparam int          DATA_LO = 'h7e00 >> 3;
  localparam int          DATA_HI = 'h8200 >> 3;

  logic                  clk;
  logic                  reset;
  rv_core_pkg::word_t    entry;
  rv_core_pkg::word_t    stackptr;
  logic                  halted;
  logic                  bus_reqcyc;
  logic                  bus_respack;
  rv_core_pkg::word_t    bus_req;
  rv_core_pkg::bus_tag_t bus_reqtag;
  logic                  bus_respcyc;
  logic                  bus_reqack;
  rv_core_pkg::word_t    bus_resp;
  rv_core_pkg::bus_tag_t bus_resptag;
  logic [31:0]           rand_word;
  logic [31:0]           gen_state;
  int                    req_count;
  int                    mem_errors;
  int                    errors;
  int                    wait_cnt;
  int                    count_at_halt;

  logic [31:0] prog [$];
  logic [63:0] ref_regs [32];
  logic [63:0] ref_mem [8192];
  logic [63:0] init_mem [8192];
  bit          touched [8192];

  rv_core_top #(.BLOCK_BEATS(BLOCK_BEATS)) u_rv_core_top (.*);

  tb_mem_model #(.BLOCK_BEATS(BLOCK_BEATS)) u_mem (.err_count(mem_errors), .*);

  always #20 clk = ~clk;

  // delay stream for the memory model, continuing the program stream
  always @(posedge clk) begin
    rand_word <= xorshift32(rand_word);
  end

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw_rand(output logic [31:0] r);
    gen_state = xorshift32(gen_state);
    r = gen_state;
  endtask

  task automatic check_eq(string name, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      errors = errors + 1;
      $display("Error at %0t: %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic emit_store(logic [11:0] off, logic [4:0] rs2);
    logic [63:0] ea;
    ea = ref_regs[2] + {{52{off[11]}}, off};
    prog.push_back({off[11:5], rs2, 5'd2, 3'b011, off[4:0], rv_core_pkg::OPC_STORE});
    ref_mem[ea[15:3]] = ref_regs[rs2];
    touched[ea[15:3]] = 1'b1;
  endtask

  // builds the program and runs it on the reference registers and memory
  task automatic gen_program();
    logic [31:0] r;
    logic [31:0] s;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [11:0] off;
    logic [63:0] ea;
    logic [63:0] a;
    logic [63:0] b;
    int          k;
    for (int i = 0; i < N_RAND; i++) begin
      draw_rand(r);
      draw_rand(s);
      rd = s[4:0];
      // x0 and x2 are never targets
      if (rd == 5'd0 || rd == 5'd2) begin
        rd = rd + 5'd1;
      end
      rs1 = s[9:5];
      rs2 = s[14:10];
      imm = s[26:15];
      off = 12'((int'(s[31:26]) - 32) * 8);
      a = ref_regs[rs1];
      b = ref_regs[rs2];
      ea = ref_regs[2] + {{52{off[11]}}, off};
      case (r % 9)
        0: begin
          prog.push_back({imm, rs1, 3'b000, rd, rv_core_pkg::OPC_OP_IMM});
          ref_regs[rd] = a + {{52{imm[11]}}, imm};
        end
        1: begin
          prog.push_back({7'h00, rs2, rs1, 3'b000, rd, rv_core_pkg::OPC_OP});
          ref_regs[rd] = a + b;
        end
        2: begin
          prog.push_back({7'h20, rs2, rs1, 3'b000, rd, rv_core_pkg::OPC_OP});
          ref_regs[rd] = a - b;
        end
        3: begin
          prog.push_back({7'h00, rs2, rs1, 3'b111, rd, rv_core_pkg::OPC_OP});
          ref_regs[rd] = a & b;
        end
        4: begin
          prog.push_back({7'h00, rs2, rs1, 3'b110, rd, rv_core_pkg::OPC_OP});
          ref_regs[rd] = a | b;
        end
        5: begin
          prog.push_back({7'h00, rs2, rs1, 3'b100, rd, rv_core_pkg::OPC_OP});
          ref_regs[rd] = a ^ b;
        end
        6: begin
          prog.push_back({r[31:12], rd, rv_core_pkg::OPC_LUI});
          ref_regs[rd] = {{32{r[31]}}, r[31:12], 12'b0};
        end
        7: begin
          prog.push_back({off, 5'd2, 3'b011, rd, rv_core_pkg::OPC_LOAD});
          ref_regs[rd] = ref_mem[ea[15:3]];
        end
        default: emit_store(off, rs2);
      endcase
    end
    // dump every register so wrong values land in memory
    k = 0;
    for (int i = 1; i < 32; i++) begin
      if (i != 2) begin
        emit_store(12'(-256 + 8 * k), 5'(i));
        k = k + 1;
      end
    end
    prog.push_back(32'h0000_0073);
  endtask

  task automatic build_memory();
    logic [31:0] r;
    logic [63:0] addr;
    for (int i = 0; i < 8192; i++) begin
      init_mem[i] = {32'h5a5a_0000 ^ 32'(i), ~(32'(i) << 3)};
      touched[i] = 1'b0;
    end
    for (int i = DATA_LO; i < DATA_HI; i++) begin
      draw_rand(r);
      init_mem[i][63:32] = r;
      draw_rand(r);
      init_mem[i][31:0] = r;
    end
    for (int i = 0; i < 8192; i++) begin
      ref_mem[i] = init_mem[i];
    end
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    ref_regs[2] = STACK;
    gen_program();
    for (int i = 0; i < 8192; i++) begin
      u_mem.mem[i] = init_mem[i];
    end
    for (int i = 0; i < prog.size(); i++) begin
      addr = ENTRY + 64'(4 * i);
      if (addr[2]) begin
        u_mem.mem[addr[15:3]][63:32] = prog[i];
      end else begin
        u_mem.mem[addr[15:3]][31:0] = prog[i];
      end
    end
    rand_word = gen_state;
  endtask

  initial begin
    errors = 0;
    clk = 1'b0;
    reset = 1'b1;
    entry = ENTRY;
    stackptr = STACK;
    gen_state = 32'h1b69_6ea0;
    build_memory();
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    // quiet bus until the first request beat
    wait_cnt = 0;
    @(posedge clk);
    while (!bus_reqcyc && wait_cnt < 100) begin
      check_eq("bus_respack", 64'd0, 64'(bus_respack));
      check_eq("halted", 64'd0, 64'(halted));
      wait_cnt = wait_cnt + 1;
      @(posedge clk);
    end
    if (!bus_reqcyc) begin
      $display("no bus request appeared after reset");
      $display("TESTBENCH FAILED");
      $finish;
    end
    check_eq("bus_req", ENTRY & ~64'(BLOCK_BEATS * 8 - 1), bus_req);
    check_eq("bus_reqtag", 64'd0, 64'(bus_reqtag));

    wait_cnt = 0;
    while (!halted && wait_cnt < 50000) begin
      wait_cnt = wait_cnt + 1;
      @(posedge clk);
    end
    if (!halted) begin
      $display("core did not halt within the timeout");
      $display("TESTBENCH FAILED");
      $finish;
    end

    count_at_halt = req_count;
    repeat (50) begin
      @(posedge clk);
      check_eq("halted", 64'd1, 64'(halted));
      check_eq("request count", 64'(count_at_halt), 64'(req_count));
    end

    for (int i = 0; i < 32; i++) begin
      check_eq($sformatf("x%0d", i), ref_regs[i], u_rv_core_top.u_register_decode.regs[i]);
    end
    for (int i = DATA_LO; i < DATA_HI; i++) begin
      check_eq($sformatf("mem[%h]", i * 8), ref_mem[i], u_mem.mem[i]);
      if (!touched[i]) begin
        check_eq($sformatf("untouched mem[%h]", i * 8), init_mem[i], u_mem.mem[i]);
      end
    end

    $display("checks done: %0d errors, %0d bus errors", errors, mem_errors);
    if (errors == 0 && mem_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
